/* hw/uart_pkg.sv */
package uart_pkg;

    // **************************************************
    // types shared by the receiver and the transmitter
    // **************************************************

    // clock cycles per bit period, at least 4.
    typedef logic [15:0] baud_div_t;

    typedef enum logic [1:0] {
        PAR_NONE,
        PAR_EVEN,
        PAR_ODD
    } parity_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP,
        WAIT
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    // parity bit for a character of up to 8 bits, unused upper bits zero.
    function automatic logic parity(input logic [7:0] data, input parity_mode_e mode);
        logic ones;
        ones = ^data;
        case (mode)
            PAR_EVEN: return ones;
            PAR_ODD:  return ~ones;
            default:  return 1'b0;
        endcase
    endfunction

endpackage

/* hw/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  uart_pkg::baud_div_t    clk_divider_i,
    input  uart_pkg::parity_mode_e parity_mode_i,
    input  logic                   uart_rx_i,
    input  logic                   rx_ready_i,
    output logic                   rx_valid_o,
    output logic [DATA_WIDTH-1:0]  rx_data_o,
    output logic                   parity_err_o
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH);

    rx_state_e             state;
    baud_div_t             baud_cnt;
    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  baud_en;
    logic                  baud_done;
    logic                  bit_done;
    logic                  start_bit_check;
    logic                  parity_exp;
    logic                  word_done;
    logic                  rx_handshake;

    // **************************************************
    // frame state machine
    // **************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state        <= IDLE;
            bit_cnt      <= '0;
            parity_err_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!uart_rx_i) begin
                        state        <= START;
                        bit_cnt      <= '0;
                        parity_err_o <= 1'b0;
                    end
                end
                START: begin
                    // a line that is high again at mid-bit was a glitch.
                    if (start_bit_check) begin
                        state <= uart_rx_i ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (baud_done) begin
                        if (bit_done) begin
                            bit_cnt <= '0;
                            state   <= (parity_mode_i == PAR_NONE) ? STOP : PARITY;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PARITY: begin
                    if (baud_done) begin
                        state        <= STOP;
                        parity_err_o <= (parity_exp != uart_rx_i);
                    end
                end
                STOP: begin
                    if (baud_done) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // data bits are taken at the sample point of each bit.
    always_ff @(posedge clk_i) begin
        if ((state == DATA) && baud_done) begin
            rx_data[bit_cnt] <= uart_rx_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            baud_cnt <= '0;
        end else if (!baud_en || baud_done || start_bit_check) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign baud_en         = (state inside {START, DATA, PARITY, STOP});
    assign baud_done       = (baud_cnt == clk_divider_i - 16'd1);
    assign bit_done        = (bit_cnt == CNT_W'(DATA_WIDTH - 1));
    assign start_bit_check = (state == START) && (baud_cnt == (clk_divider_i >> 1) - 16'd1);
    assign parity_exp      = parity(8'(rx_data), parity_mode_i);

    // **************************************************
    // output word
    // **************************************************

    assign word_done    = (state == WAIT) && !parity_err_o;
    assign rx_handshake = rx_valid_o && rx_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_valid_o <= 1'b0;
        end else if (word_done) begin
            rx_valid_o <= 1'b1;
        end else if (rx_handshake) begin
            rx_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (word_done) begin
            rx_data_o <= rx_data;
        end
    end

    a_rx_data_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rx_valid_o && !rx_ready_i && !word_done |=> $stable(rx_data_o));

    a_rx_state_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state inside {IDLE, START, DATA, PARITY, STOP, WAIT});

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  uart_pkg::baud_div_t    clk_divider_i,
    input  uart_pkg::parity_mode_e parity_mode_i,
    input  logic                   s_valid_i,
    input  logic [DATA_WIDTH-1:0]  s_data_i,
    output logic                   s_ready_o,
    output logic                   uart_tx_o
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH);

    tx_state_e             state;
    baud_div_t             baud_cnt;
    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] tx_shift;
    logic                  tx_parity;
    logic                  baud_done;
    logic                  bit_done;
    logic                  s_handshake;

    assign s_ready_o   = (state == TX_IDLE);
    assign s_handshake = s_valid_i && s_ready_o;
    assign baud_done   = (baud_cnt == clk_divider_i - 16'd1);
    assign bit_done    = (bit_cnt == CNT_W'(DATA_WIDTH - 1));

    // **************************************************
    // frame state machine with registered line output
    // **************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state     <= TX_IDLE;
            bit_cnt   <= '0;
            uart_tx_o <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (s_handshake) begin
                        state     <= TX_START;
                        bit_cnt   <= '0;
                        uart_tx_o <= 1'b0;
                    end
                end
                TX_START: begin
                    if (baud_done) begin
                        state     <= TX_DATA;
                        uart_tx_o <= tx_shift[0];
                    end
                end
                TX_DATA: begin
                    if (baud_done) begin
                        if (bit_done) begin
                            if (parity_mode_i == PAR_NONE) begin
                                state     <= TX_STOP;
                                uart_tx_o <= 1'b1;
                            end else begin
                                state     <= TX_PARITY;
                                uart_tx_o <= tx_parity;
                            end
                        end else begin
                            bit_cnt   <= bit_cnt + 1'b1;
                            uart_tx_o <= tx_shift[0];
                        end
                    end
                end
                TX_PARITY: begin
                    if (baud_done) begin
                        state     <= TX_STOP;
                        uart_tx_o <= 1'b1;
                    end
                end
                TX_STOP: begin
                    // line is already high for the stop bit.
                    if (baud_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state     <= TX_IDLE;
                    uart_tx_o <= 1'b1;
                end
            endcase
        end
    end

    // word and parity are captured on acceptance, then shifted out lsb first.
    always_ff @(posedge clk_i) begin
        if (s_handshake) begin
            tx_shift  <= s_data_i;
            tx_parity <= parity(8'(s_data_i), parity_mode_i);
        end else if (baud_done && (state inside {TX_START, TX_DATA})) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            baud_cnt <= '0;
        end else if ((state == TX_IDLE) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state == TX_IDLE) |-> uart_tx_o);

endmodule

/* hw/uart_rx_fifo.sv */
`timescale 1ns/1ns

module uart_rx_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  wr_valid_i,
    input  logic [DATA_WIDTH-1:0] wr_data_i,
    input  logic                  rd_ready_i,
    output logic                  wr_ready_o,
    output logic                  rd_valid_o,
    output logic [DATA_WIDTH-1:0] rd_data_o,
    output logic                  overrun_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W:0]       wr_ptr;
    logic [ADDR_W:0]       rd_ptr;
    logic [ADDR_W:0]       fill;
    logic                  full;
    logic                  empty;
    logic                  wr_en;
    logic                  rd_en;

    // pointers carry one extra wrap bit to tell full from empty.
    assign fill  = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // every word is taken; one that finds the FIFO full is dropped.
    assign wr_ready_o = 1'b1;
    assign wr_en      = wr_valid_i && !full;
    assign rd_valid_o = !empty;
    assign rd_en      = rd_valid_o && rd_ready_i;
    assign rd_data_o  = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            overrun_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            overrun_o <= wr_valid_i && full;
        end
    end

    // a read from an empty FIFO would wrap the fill level past the depth.
    a_fifo_no_empty_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        int'(fill) <= FIFO_DEPTH);

endmodule

/* hw/uart_core.sv */
`timescale 1ns/1ns

module uart_core #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  uart_pkg::baud_div_t    clk_divider_i,
    input  uart_pkg::parity_mode_e parity_mode_i,
    input  logic                   uart_rx_i,
    input  logic                   s_valid_i,
    input  logic [DATA_WIDTH-1:0]  s_data_i,
    input  logic                   m_ready_i,
    output logic                   uart_tx_o,
    output logic                   s_ready_o,
    output logic                   m_valid_o,
    output logic [DATA_WIDTH-1:0]  m_data_o,
    output logic                   parity_err_o,
    output logic                   rx_overrun_o
);

    // receiver to FIFO stream.
    logic                  rx_valid;
    logic                  rx_ready;
    logic [DATA_WIDTH-1:0] rx_data;

    uart_rx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uart_rx_i0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clk_divider_i (clk_divider_i),
        .parity_mode_i (parity_mode_i),
        .uart_rx_i     (uart_rx_i),
        .rx_ready_i    (rx_ready),
        .rx_valid_o    (rx_valid),
        .rx_data_o     (rx_data),
        .parity_err_o  (parity_err_o)
    );

    uart_rx_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uart_rx_fifo_i0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_valid_i (rx_valid),
        .wr_data_i  (rx_data),
        .rd_ready_i (m_ready_i),
        .wr_ready_o (rx_ready),
        .rd_valid_o (m_valid_o),
        .rd_data_o  (m_data_o),
        .overrun_o  (rx_overrun_o)
    );

    uart_tx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uart_tx_i0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clk_divider_i (clk_divider_i),
        .parity_mode_i (parity_mode_i),
        .s_valid_i     (s_valid_i),
        .s_data_i      (s_data_i),
        .s_ready_o     (s_ready_o),
        .uart_tx_o     (uart_tx_o)
    );

endmodule

/* tests/tb_uart_core.sv */
`timescale 1ns/1ns

module tb_uart_core;
    import uart_pkg::*;

    localparam int DATA_WIDTH   = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int DIV          = 8;
    localparam int RESET_CYCLES = 8;
    // worst-case frame with parity, plus one bit of idle line.
    localparam int FRAME_SLOT   = 12 * DIV;
    localparam int FRAMES       = 36;
    localparam int TEST_COUNT   = 7;
    localparam int CYCLE_LIMIT  =
        3 * (2 * RESET_CYCLES + FRAMES * FRAME_SLOT + TEST_COUNT * 4 * DIV) / 2;

    logic                  clk_i;
    logic                  rstn_i;
    baud_div_t             clk_divider_i;
    parity_mode_e          parity_mode_i;
    logic                  s_valid_i;
    logic [DATA_WIDTH-1:0] s_data_i;
    logic                  m_ready_i;
    logic                  uart_tx_o;
    logic                  s_ready_o;
    logic                  m_valid_o;
    logic [DATA_WIDTH-1:0] m_data_o;
    logic                  parity_err_o;
    logic                  rx_overrun_o;

    logic        line_bb;
    logic        loopback;
    logic        uart_rx_line;
    logic [31:0] lcg_state;
    logic [7:0]  rx_q[$];
    int          overrun_cnt = 0;
    int          perr_cnt = 0;
    int          cycles = 0;
    int          word_base;
    int          ovr_base;
    int          perr_base;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    // line source mux.
    assign uart_rx_line = loopback ? uart_tx_o : line_bb;

    uart_core #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uart_core_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clk_divider_i (clk_divider_i),
        .parity_mode_i (parity_mode_i),
        .uart_rx_i     (uart_rx_line),
        .s_valid_i     (s_valid_i),
        .s_data_i      (s_data_i),
        .m_ready_i     (m_ready_i),
        .uart_tx_o     (uart_tx_o),
        .s_ready_o     (s_ready_o),
        .m_valid_o     (m_valid_o),
        .m_data_o      (m_data_o),
        .parity_err_o  (parity_err_o),
        .rx_overrun_o  (rx_overrun_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // output port monitor, sampled away from the driving edge.
    always @(negedge clk_i) begin
        if (m_valid_o && m_ready_i) begin
            rx_q.push_back(m_data_o);
        end
        if (rx_overrun_o) begin
            overrun_cnt++;
        end
        if (parity_err_o) begin
            perr_cnt++;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // **************************************************
    // helpers
    // **************************************************

    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // parity bit that makes the count of ones even or odd.
    function automatic logic frame_parity(input logic [7:0] data, input parity_mode_e mode);
        int ones;
        ones = 0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            ones += int'(data[i]);
        end
        return (mode == PAR_ODD) ? (ones % 2 == 0) : (ones % 2 == 1);
    endfunction

    task automatic expect_word(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic reset_dut();
        @(posedge clk_i);
        rstn_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;
    endtask

    task automatic setup(input parity_mode_e mode, input logic lb);
        @(posedge clk_i);
        parity_mode_i <= mode;
        loopback      <= lb;
        word_base = rx_q.size();
        ovr_base  = overrun_cnt;
        perr_base = perr_cnt;
    endtask

    task automatic send_byte(input logic [7:0] data);
        @(posedge clk_i);
        s_valid_i <= 1'b1;
        s_data_i  <= data;
        @(negedge clk_i);
        while (!s_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        s_valid_i <= 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        line_bb <= b;
        repeat (DIV) @(posedge clk_i);
    endtask

    task automatic drive_frame(input logic [7:0] data, input parity_mode_e mode,
                               input logic flip);
        @(posedge clk_i);
        drive_bit(1'b0);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            drive_bit(data[i]);
        end
        if (mode != PAR_NONE) begin
            drive_bit(frame_parity(data, mode) ^ flip);
        end
        drive_bit(1'b1);
    endtask

    task automatic wait_words(input int n);
        while (rx_q.size() - word_base < n) @(posedge clk_i);
    endtask

    // **************************************************
    // tests
    // **************************************************

    task automatic loopback_test(input parity_mode_e mode, input string name);
        int         start_errors;
        logic [7:0] sent[$];
        logic [7:0] data;
        start_errors = errors;
        setup(mode, 1'b1);
        for (int i = 0; i < 8; i++) begin
            data = next_random();
            sent.push_back(data);
            send_byte(data);
        end
        wait_words(8);
        @(negedge clk_i);
        while (!s_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        loopback <= 1'b0;
        // one frame with the parity bit computed here.
        data = next_random();
        sent.push_back(data);
        drive_frame(data, mode, 1'b0);
        wait_words(9);
        repeat (2 * DIV) @(posedge clk_i);
        expect_count("received words", 9, rx_q.size() - word_base);
        for (int i = 0; i < 9; i++) begin
            expect_word("m_data_o", sent[i], rx_q[word_base + i]);
        end
        check_flag("parity_err_o seen", 1'b0, perr_cnt != perr_base);
        report_test(name, start_errors);
    endtask

    task automatic parity_error_test();
        int         start_errors;
        logic [7:0] data;
        start_errors = errors;
        setup(PAR_EVEN, 1'b0);
        drive_frame(next_random(), PAR_EVEN, 1'b1);
        repeat (2 * DIV) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("parity_err_o", 1'b1, parity_err_o);
        expect_count("words after bad parity", 0, rx_q.size() - word_base);
        data = next_random();
        drive_frame(data, PAR_EVEN, 1'b0);
        wait_words(1);
        @(negedge clk_i);
        expect_word("m_data_o", data, rx_q[word_base]);
        check_flag("parity_err_o", 1'b0, parity_err_o);
        report_test("parity error", start_errors);
    endtask

    task automatic false_start_test();
        int         start_errors;
        logic [7:0] data;
        start_errors = errors;
        setup(PAR_NONE, 1'b0);
        @(posedge clk_i);
        line_bb <= 1'b0;
        repeat (DIV / 2 - 2) @(posedge clk_i);
        line_bb <= 1'b1;
        repeat (2 * DIV) @(posedge clk_i);
        @(negedge clk_i);
        expect_count("words after false start", 0, rx_q.size() - word_base);
        check_flag("parity_err_o", 1'b0, parity_err_o);
        data = next_random();
        drive_frame(data, PAR_NONE, 1'b0);
        wait_words(1);
        expect_word("m_data_o", data, rx_q[word_base]);
        report_test("false start", start_errors);
    endtask

    task automatic overrun_test();
        int         start_errors;
        logic [7:0] sent[$];
        logic [7:0] data;
        start_errors = errors;
        setup(PAR_NONE, 1'b0);
        @(posedge clk_i);
        m_ready_i <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            data = next_random();
            sent.push_back(data);
            drive_frame(data, PAR_NONE, 1'b0);
        end
        repeat (2 * DIV) @(posedge clk_i);
        @(negedge clk_i);
        expect_count("rx_overrun_o pulses", 1, overrun_cnt - ovr_base);
        check_flag("m_valid_o", 1'b1, m_valid_o);
        @(posedge clk_i);
        m_ready_i <= 1'b1;
        wait_words(FIFO_DEPTH);
        repeat (2 * DIV) @(posedge clk_i);
        expect_count("drained words", FIFO_DEPTH, rx_q.size() - word_base);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            expect_word("m_data_o", sent[i], rx_q[word_base + i]);
        end
        report_test("fifo overrun", start_errors);
    endtask

    task automatic tx_pacing_test();
        int         start_errors;
        int         low_cycles;
        int         frame_len;
        logic [7:0] data;
        start_errors = errors;
        frame_len = (DATA_WIDTH + 3) * DIV;
        // reset lands in the start bit of a frame, with the line low.
        send_byte(next_random());
        reset_dut();
        @(negedge clk_i);
        check_flag("uart_tx_o", 1'b1, uart_tx_o);
        check_flag("s_ready_o", 1'b1, s_ready_o);
        check_flag("m_valid_o", 1'b0, m_valid_o);
        check_flag("parity_err_o", 1'b0, parity_err_o);
        check_flag("rx_overrun_o", 1'b0, rx_overrun_o);
        setup(PAR_ODD, 1'b1);
        data = next_random();
        send_byte(data);
        low_cycles = 0;
        @(negedge clk_i);
        while (!s_ready_o) begin
            low_cycles++;
            @(negedge clk_i);
        end
        if (low_cycles < frame_len - 1 || low_cycles > frame_len + 1) begin
            $display("** Error s_ready_o low cycles: expected %h, got %h",
                     frame_len, low_cycles);
            errors++;
        end
        wait_words(1);
        expect_word("m_data_o", data, rx_q[word_base]);
        report_test("transmitter pacing", start_errors);
    endtask

    initial begin
        rstn_i        = 1'b0;
        clk_divider_i = baud_div_t'(DIV);
        parity_mode_i = PAR_NONE;
        s_valid_i     = 1'b0;
        s_data_i      = '0;
        m_ready_i     = 1'b1;
        line_bb       = 1'b1;
        loopback      = 1'b1;
        lcg_state     = 32'hdc44_4386;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        word_base     = 0;
        ovr_base      = 0;
        perr_base     = 0;
        reset_dut();
        loopback_test(PAR_NONE, "loopback no parity");
        loopback_test(PAR_EVEN, "loopback even parity");
        loopback_test(PAR_ODD, "loopback odd parity");
        parity_error_test();
        false_start_test();
        overrun_test();
        tx_pacing_test();
        $display("tests: %0d ok, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* flist.f */
hw/uart_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_rx_fifo.sv
hw/uart_core.sv
tests/tb_uart_core.sv

/* Makefile */
SIM    := verilator
FLAGS  := --binary --timing --assert
TOP    := tb_uart_core
FLIST  := flist.f
BUILD  := obj_dir
LOG    := sim.log

BIN  := $(BUILD)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'Testbench passed' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
